/* vcache_system.f */
logic/cache_geom_pkg.sv
logic/dram_pkg.sv
logic/bank_router.sv
logic/vcache_bank.sv
logic/dram_arbiter.sv
logic/dram_model.sv
logic/vcache_system.sv
test/vcache_system_asserts.sv
test/vcache_system_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vcache_system.f --top-module vcache_system_tb \
  -o vcache_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vcache_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1

/* test/vcache_system_tb.sv */
// reads only touch written words since memory powers up unknown, and tags stay distinct in flight
module vcache_system_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cache_geom_pkg::*;
  import dram_pkg::*;

  localparam int num_tags       = 1 << req_tag_w;
  localparam int random_ops     = 400;
  localparam int timeout_cycles = (64 + random_ops) * 40;

  logic        clk = 1'b0;
  logic        reset;
  logic        req_v_i;
  logic        req_we_i;
  word_addr_t  req_addr_i;
  data_t       req_data_i;
  req_tag_t    req_tag_i;
  logic        req_ready_o;
  logic        rsp_v_o;
  logic        rsp_we_o;
  data_t       rsp_data_o;
  req_tag_t    rsp_tag_o;
  logic        rsp_ready_i = 1'b1;
  miss_count_t miss_count_o;

  // shadow of memory and of each bank's tag array
  data_t     shadow_mem [dram_words];
  logic      shadow_valid [num_banks][num_sets];
  line_tag_t shadow_tag [num_banks][num_sets];

  data_t       exp_data [num_tags];
  logic        exp_we [num_tags];
  int unsigned issue_cnt [num_tags];
  int unsigned answer_cnt [num_tags];
  int unsigned issued;
  int unsigned answered;
  int unsigned ref_misses;
  int unsigned err_count;
  int unsigned cycle_count;
  req_tag_t    next_tag;
  logic        random_ready = 1'b0;
  logic [31:0] rng = 32'hf8ab0311;
  // second stream for back-pressure
  logic [31:0] rng_ready = 32'hf8ab0311 ^ 32'h9e3779b9;

  vcache_system u_dut (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // expected response from the cache rules, flags a read miss
  function automatic data_t predict_response(input logic we, input word_addr_t addr,
                                             input data_t data, output logic miss);
    bank_id_t  bank;
    set_idx_t  line_set;
    line_tag_t ltag;
    bank     = addr[bank_id_w-1:0];
    line_set = addr[set_lsb +: set_idx_w];
    ltag     = addr[tag_lsb +: line_tag_w];
    miss     = 1'b0;
    if (we) begin
      // a cached copy always follows memory, tags unchanged
      shadow_mem[addr] = data;
      return '0;
    end
    if (!(shadow_valid[bank][line_set] && shadow_tag[bank][line_set] == ltag)) begin
      miss = 1'b1;
      shadow_valid[bank][line_set] = 1'b1;
      shadow_tag[bank][line_set]   = ltag;
    end
    return shadow_mem[addr];
  endfunction

  task automatic send_request(input logic we, input word_addr_t addr, input data_t data);
    logic miss;
    @(negedge clk);
    req_v_i    = 1'b1;
    req_we_i   = we;
    req_addr_i = addr;
    req_data_i = data;
    req_tag_i  = next_tag;
    #1;
    while (!req_ready_o) begin
      @(negedge clk);
      #1;
    end
    exp_data[next_tag] = predict_response(we, addr, data, miss);
    exp_we[next_tag]   = we;
    issue_cnt[next_tag]++;
    issued++;
    if (miss) ref_misses++;
    next_tag++;
    @(posedge clk);
  endtask

  task automatic drain_responses();
    @(negedge clk);
    req_v_i = 1'b0;
    #1;
    while (answered != issued) begin
      @(negedge clk);
      #1;
    end
  endtask

  always @(negedge clk) begin
    req_tag_t tag;
    if (random_ready) begin
      rng_ready   = xorshift(rng_ready);
      rsp_ready_i = (rng_ready[1:0] != 2'b00);
    end else begin
      rsp_ready_i = 1'b1;
    end
    // seen here, the transfer happens at the next rising edge
    if (reset && rsp_v_o === 1'b1 && rsp_ready_i) begin
      tag = rsp_tag_o;
      if (answer_cnt[tag] >= issue_cnt[tag]) begin
        err_count++;
        $display("response carries tag %0d, which has no open request", tag);
      end else begin
        compare_value("rsp_we_o", 32'(rsp_we_o), 32'(exp_we[tag]));
        compare_value("rsp_data_o", rsp_data_o, exp_data[tag]);
        answer_cnt[tag]++;
        answered++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, %0d of %0d requests answered",
               cycle_count, answered, issued);
      $display("errors: %0d plus the timeout", err_count);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    logic       we;
    word_addr_t addr;
    for (int b = 0; b < num_banks; b++) begin
      for (int s = 0; s < num_sets; s++) shadow_valid[b][s] = 1'b0;
    end
    reset      = 1'b0;
    req_v_i    = 1'b0;
    req_we_i   = 1'b0;
    req_addr_i = '0;
    req_data_i = '0;
    req_tag_i  = '0;
    next_tag   = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;

    // fill region 0..63, no allocation on writes
    for (int a = 0; a < 64; a++) begin
      rng = xorshift(rng);
      send_request(1'b1, word_addr_t'(a), rng);
    end
    drain_responses();
    compare_value("miss_count_o", 32'(miss_count_o), 32'd0);

    for (int a = 0; a < 64; a++) send_request(1'b0, word_addr_t'(a), '0);
    drain_responses();
    compare_value("miss_count_o", 32'(miss_count_o), 32'd64);

    // words 64..127 share sets with 0..63
    for (int a = 64; a < 128; a++) begin
      rng = xorshift(rng);
      send_request(1'b1, word_addr_t'(a), rng);
    end
    send_request(1'b0, 12'd69, '0);
    send_request(1'b0, 12'd69, '0);
    send_request(1'b0, 12'd5, '0);
    send_request(1'b0, 12'd69, '0);
    drain_responses();
    compare_value("miss_count_o", 32'(miss_count_o), 32'd67);

    // word 10 is still cached from the read pass
    send_request(1'b1, 12'd10, 32'h5a5a_0010);
    send_request(1'b0, 12'd10, '0);
    drain_responses();
    compare_value("miss_count_o", 32'(miss_count_o), 32'd67);

    random_ready = 1'b1;
    for (int n = 0; n < random_ops; n++) begin
      rng  = xorshift(rng);
      we   = rng[0];
      addr = word_addr_t'(rng[7:1]);
      rng  = xorshift(rng);
      send_request(we, addr, rng);
    end
    random_ready = 1'b0;
    drain_responses();
    compare_value("miss_count_o", 32'(miss_count_o), 32'(miss_count_t'(ref_misses)));

    $display("run finished: %0d requests, %0d misses, %0d errors", issued, ref_misses, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* test/vcache_system_asserts.sv */
// tags are assumed distinct while in flight, and a request open longer than max_wait cycles fails
module vcache_system_asserts (
  input logic clk,
  input logic reset,
  input logic req_v_i,
  input logic req_ready_i,
  input cache_geom_pkg::req_tag_t req_tag_i,
  input logic rsp_v_i,
  input logic rsp_ready_i,
  input logic rsp_we_i,
  input cache_geom_pkg::data_t rsp_data_i,
  input cache_geom_pkg::req_tag_t rsp_tag_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import cache_geom_pkg::*;

  localparam int num_tags = 1 << req_tag_w;
  localparam int max_wait = 100;

  logic [num_tags-1:0] open_r;
  int unsigned age_r [num_tags];
  logic late;

  always_ff @(posedge clk) begin
    if (!reset) begin
      open_r <= '0;
    end else begin
      if (rsp_v_i && rsp_ready_i) open_r[rsp_tag_i] <= 1'b0;
      if (req_v_i && req_ready_i) open_r[req_tag_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < num_tags; t++) begin
      age_r[t] <= open_r[t] ? age_r[t] + 1 : 0;
    end
  end

  always_comb begin
    late = 1'b0;
    for (int t = 0; t < num_tags; t++) begin
      if (open_r[t] && age_r[t] > max_wait) late = 1'b1;
    end
  end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!reset)
    rsp_v_i && !rsp_ready_i |=> rsp_v_i && $stable(rsp_we_i) && $stable(rsp_data_i)
                                && $stable(rsp_tag_i))
    else $error("response fields changed while stalled");

  a_reset_ready: assert property (@(posedge clk) !reset && $past(!reset) |-> !req_ready_i)
    else $error("req_ready_o high during reset");

  a_answered: assert property (@(posedge clk) disable iff (!reset) !late)
    else $error("a request waited more than %0d cycles for its response", max_wait);

endmodule

bind vcache_system vcache_system_asserts u_asserts (
  .clk(clk), .reset(reset), .req_v_i(req_v_i), .req_ready_i(req_ready_o),
  .req_tag_i(req_tag_i), .rsp_v_i(rsp_v_o), .rsp_ready_i(rsp_ready_i),
  .rsp_we_i(rsp_we_o), .rsp_data_i(rsp_data_o), .rsp_tag_i(rsp_tag_o)
);

/* logic/vcache_system.sv */
// geometry is fixed by the packages and response fields hold while rsp_ready_i is low
module vcache_system (
  input  logic clk,
  input  logic reset,
  input  logic req_v_i,
  input  logic req_we_i,
  input  cache_geom_pkg::word_addr_t req_addr_i,
  input  cache_geom_pkg::data_t req_data_i,
  input  cache_geom_pkg::req_tag_t req_tag_i,
  output logic req_ready_o,
  output logic rsp_v_o,
  output logic rsp_we_o,
  output cache_geom_pkg::data_t rsp_data_o,
  output cache_geom_pkg::req_tag_t rsp_tag_o,
  input  logic rsp_ready_i,
  output dram_pkg::miss_count_t miss_count_o
);
  import cache_geom_pkg::*;
  import dram_pkg::*;

  logic [num_banks-1:0] bank_req_v;
  logic                 bank_req_we;
  word_addr_t           bank_req_addr;
  data_t                bank_req_data;
  req_tag_t             bank_req_tag;
  logic [num_banks-1:0] bank_req_ready;
  logic [num_banks-1:0] bank_rsp_v;
  logic [num_banks-1:0] bank_rsp_we;
  data_t [num_banks-1:0]    bank_rsp_data;
  req_tag_t [num_banks-1:0] bank_rsp_tag;
  logic [num_banks-1:0] bank_rsp_yumi;

  logic [num_banks-1:0] mem_v;
  logic [num_banks-1:0] mem_we;
  dram_addr_t [num_banks-1:0] mem_addr;
  data_t [num_banks-1:0]      mem_wdata;
  logic [num_banks-1:0] mem_ready;
  logic [num_banks-1:0] mem_rdata_v;
  data_t                mem_rdata;

  logic       dram_v;
  logic       dram_we;
  dram_addr_t dram_addr;
  data_t      dram_wdata;
  logic       dram_rdata_v;
  data_t      dram_rdata;

  bank_router u_router (
    .clk(clk), .reset(reset),
    .req_v_i(req_v_i), .req_we_i(req_we_i), .req_addr_i(req_addr_i),
    .req_data_i(req_data_i), .req_tag_i(req_tag_i), .req_ready_o(req_ready_o),
    .rsp_v_o(rsp_v_o), .rsp_we_o(rsp_we_o), .rsp_data_o(rsp_data_o),
    .rsp_tag_o(rsp_tag_o), .rsp_ready_i(rsp_ready_i),
    .bank_req_v_o(bank_req_v), .bank_req_we_o(bank_req_we),
    .bank_req_addr_o(bank_req_addr), .bank_req_data_o(bank_req_data),
    .bank_req_tag_o(bank_req_tag), .bank_req_ready_i(bank_req_ready),
    .bank_rsp_v_i(bank_rsp_v), .bank_rsp_we_i(bank_rsp_we),
    .bank_rsp_data_i(bank_rsp_data), .bank_rsp_tag_i(bank_rsp_tag),
    .bank_rsp_yumi_o(bank_rsp_yumi)
  );

  for (genvar i = 0; i < num_banks; i++) begin : g_bank
    vcache_bank u_bank (
      .clk(clk), .reset(reset),
      .req_v_i(bank_req_v[i]), .req_we_i(bank_req_we), .req_addr_i(bank_req_addr),
      .req_data_i(bank_req_data), .req_tag_i(bank_req_tag), .req_ready_o(bank_req_ready[i]),
      .rsp_v_o(bank_rsp_v[i]), .rsp_we_o(bank_rsp_we[i]), .rsp_data_o(bank_rsp_data[i]),
      .rsp_tag_o(bank_rsp_tag[i]), .rsp_yumi_i(bank_rsp_yumi[i]),
      .mem_v_o(mem_v[i]), .mem_we_o(mem_we[i]), .mem_addr_o(mem_addr[i]),
      .mem_wdata_o(mem_wdata[i]), .mem_ready_i(mem_ready[i]),
      .mem_rdata_v_i(mem_rdata_v[i]), .mem_rdata_i(mem_rdata)
    );
  end

  dram_arbiter u_arbiter (
    .clk(clk), .reset(reset),
    .mem_v_i(mem_v), .mem_we_i(mem_we), .mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata),
    .mem_ready_o(mem_ready), .mem_rdata_v_o(mem_rdata_v), .mem_rdata_o(mem_rdata),
    .dram_v_o(dram_v), .dram_we_o(dram_we), .dram_addr_o(dram_addr),
    .dram_wdata_o(dram_wdata), .dram_rdata_v_i(dram_rdata_v), .dram_rdata_i(dram_rdata),
    .miss_count_o(miss_count_o)
  );

  dram_model u_dram (
    .clk(clk), .reset(reset),
    .dram_v_i(dram_v), .dram_we_i(dram_we), .dram_addr_i(dram_addr),
    .dram_wdata_i(dram_wdata), .dram_rdata_v_o(dram_rdata_v), .dram_rdata_o(dram_rdata)
  );

endmodule

/* logic/dram_model.sv */
// contents power up unknown, writes land at the accepting edge and reads return after a fixed latency
module dram_model (
  input  logic clk,
  input  logic reset,
  input  logic dram_v_i,
  input  logic dram_we_i,
  input  dram_pkg::dram_addr_t dram_addr_i,
  input  cache_geom_pkg::data_t dram_wdata_i,
  output logic dram_rdata_v_o,
  output cache_geom_pkg::data_t dram_rdata_o
);
  import cache_geom_pkg::*;
  import dram_pkg::*;

  data_t mem [dram_words];

  logic [dram_read_latency-1:0] rd_v_q;
  data_t rd_data_q [dram_read_latency];

  always_ff @(posedge clk) begin
    if (dram_v_i && dram_we_i) begin
      mem[dram_addr_i] <= dram_wdata_i;
    end
    if (dram_v_i && !dram_we_i) begin
      rd_data_q[0] <= mem[dram_addr_i];
    end
    for (int s = 1; s < dram_read_latency; s++) begin
      rd_data_q[s] <= rd_data_q[s-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      rd_v_q <= '0;
    end else begin
      rd_v_q[0] <= dram_v_i && !dram_we_i;
      for (int s = 1; s < dram_read_latency; s++) begin
        rd_v_q[s] <= rd_v_q[s-1];
      end
    end
  end

  assign dram_rdata_v_o = rd_v_q[dram_read_latency-1];
  assign dram_rdata_o   = rd_data_q[dram_read_latency-1];

endmodule

/* logic/dram_arbiter.sv */
// memory never stalls, so each cycle grants at most one bank and read data returns in grant order
module dram_arbiter (
  input  logic clk,
  input  logic reset,
  input  logic [cache_geom_pkg::num_banks-1:0] mem_v_i,
  input  logic [cache_geom_pkg::num_banks-1:0] mem_we_i,
  input  dram_pkg::dram_addr_t [cache_geom_pkg::num_banks-1:0] mem_addr_i,
  input  cache_geom_pkg::data_t [cache_geom_pkg::num_banks-1:0] mem_wdata_i,
  output logic [cache_geom_pkg::num_banks-1:0] mem_ready_o,
  output logic [cache_geom_pkg::num_banks-1:0] mem_rdata_v_o,
  output cache_geom_pkg::data_t mem_rdata_o,
  output logic dram_v_o,
  output logic dram_we_o,
  output dram_pkg::dram_addr_t dram_addr_o,
  output cache_geom_pkg::data_t dram_wdata_o,
  input  logic dram_rdata_v_i,
  input  cache_geom_pkg::data_t dram_rdata_i,
  output dram_pkg::miss_count_t miss_count_o
);
  import cache_geom_pkg::*;
  import dram_pkg::*;

  bank_id_t    last_r;
  bank_id_t    pick_id;
  logic        pick_v;
  logic        rd_grant;
  miss_count_t miss_count_r;

  // bank id travels alongside each read
  logic [dram_read_latency-1:0] rd_v_q;
  bank_id_t rd_id_q [dram_read_latency];

  always_comb begin
    bank_id_t idx;
    pick_v  = 1'b0;
    pick_id = '0;
    for (int k = num_banks; k >= 1; k--) begin
      idx = bank_id_t'(last_r + k);
      if (mem_v_i[idx]) begin
        pick_v  = 1'b1;
        pick_id = idx;
      end
    end
  end

  assign rd_grant = pick_v && !mem_we_i[pick_id];

  always_comb begin
    mem_ready_o = '0;
    mem_ready_o[pick_id] = pick_v;
  end

  assign dram_v_o     = pick_v;
  assign dram_we_o    = mem_we_i[pick_id];
  assign dram_addr_o  = mem_addr_i[pick_id];
  assign dram_wdata_o = mem_wdata_i[pick_id];

  always_ff @(posedge clk) begin
    if (!reset) begin
      last_r       <= '0;
      rd_v_q       <= '0;
      miss_count_r <= '0;
    end else begin
      if (pick_v) begin
        last_r <= pick_id;
      end
      rd_v_q[0] <= rd_grant;
      for (int s = 1; s < dram_read_latency; s++) begin
        rd_v_q[s] <= rd_v_q[s-1];
      end
      if (rd_grant) begin
        miss_count_r <= miss_count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_id_q[0] <= pick_id;
    for (int s = 1; s < dram_read_latency; s++) begin
      rd_id_q[s] <= rd_id_q[s-1];
    end
  end

  // steer returning word to the bank that asked
  always_comb begin
    mem_rdata_v_o = '0;
    mem_rdata_v_o[rd_id_q[dram_read_latency-1]] = dram_rdata_v_i && rd_v_q[dram_read_latency-1];
  end

  assign mem_rdata_o  = dram_rdata_i;
  assign miss_count_o = miss_count_r;

endmodule

/* logic/vcache_bank.sv */
// one word per line, write-through with no write-allocate, and a single request held until its response is taken
module vcache_bank (
  input  logic clk,
  input  logic reset,
  input  logic req_v_i,
  input  logic req_we_i,
  input  cache_geom_pkg::word_addr_t req_addr_i,
  input  cache_geom_pkg::data_t req_data_i,
  input  cache_geom_pkg::req_tag_t req_tag_i,
  output logic req_ready_o,
  output logic rsp_v_o,
  output logic rsp_we_o,
  output cache_geom_pkg::data_t rsp_data_o,
  output cache_geom_pkg::req_tag_t rsp_tag_o,
  input  logic rsp_yumi_i,
  output logic mem_v_o,
  output logic mem_we_o,
  output dram_pkg::dram_addr_t mem_addr_o,
  output cache_geom_pkg::data_t mem_wdata_o,
  input  logic mem_ready_i,
  input  logic mem_rdata_v_i,
  input  cache_geom_pkg::data_t mem_rdata_i
);
  import cache_geom_pkg::*;
  import dram_pkg::*;

  typedef enum logic [2:0] {idle, mem_write, mem_read, wait_fill, respond} state_e;

  state_e state_r;
  state_e state_n;
  logic   ready_r;

  logic [num_sets-1:0] valid_r;
  line_tag_t tag_mem [num_sets];
  data_t     data_mem [num_sets];

  word_addr_t addr_r;
  logic       we_r;
  data_t      wdata_r;
  req_tag_t   tag_r;
  data_t      rsp_data_r;

  set_idx_t  req_set;
  line_tag_t req_ltag;
  set_idx_t  fill_set;
  logic      hit;
  logic      accept;
  logic      fill_en;

  assign req_set  = req_addr_i[set_lsb +: set_idx_w];
  assign req_ltag = req_addr_i[tag_lsb +: line_tag_w];
  assign hit      = valid_r[req_set] && (tag_mem[req_set] == req_ltag);
  assign accept   = req_v_i && ready_r;
  assign fill_set = addr_r[set_lsb +: set_idx_w];
  assign fill_en  = (state_r == wait_fill) && mem_rdata_v_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      idle: begin
        if (accept) begin
          if (req_we_i) state_n = mem_write;
          else if (hit) state_n = respond;
          else state_n = mem_read;
        end
      end
      mem_write: if (mem_ready_i) state_n = respond;
      mem_read:  if (mem_ready_i) state_n = wait_fill;
      wait_fill: if (mem_rdata_v_i) state_n = respond;
      respond:   if (rsp_yumi_i) state_n = idle;
      default:   state_n = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_r <= idle;
      ready_r <= 1'b0;
      valid_r <= '0;
    end else begin
      state_r <= state_n;
      // ready only when back in idle, which implies an empty response slot
      ready_r <= (state_n == idle);
      if (fill_en) begin
        valid_r[fill_set] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_r     <= req_addr_i;
      we_r       <= req_we_i;
      wdata_r    <= req_data_i;
      tag_r      <= req_tag_i;
      rsp_data_r <= req_we_i ? '0 : data_mem[req_set];
    end
    // update on write hit, memory still gets the write
    if (accept && req_we_i && hit) begin
      data_mem[req_set] <= req_data_i;
    end
    if (fill_en) begin
      tag_mem[fill_set]  <= addr_r[tag_lsb +: line_tag_w];
      data_mem[fill_set] <= mem_rdata_i;
      rsp_data_r         <= mem_rdata_i;
    end
  end

  assign req_ready_o = ready_r;
  assign rsp_v_o     = (state_r == respond);
  assign rsp_we_o    = we_r;
  assign rsp_data_o  = rsp_data_r;
  assign rsp_tag_o   = tag_r;
  assign mem_v_o     = (state_r == mem_write) || (state_r == mem_read);
  assign mem_we_o    = (state_r == mem_write);
  assign mem_addr_o  = dram_addr_t'(addr_r);
  assign mem_wdata_o = wdata_r;

endmodule

/* logic/bank_router.sv */
// request steering trusts the selected bank's ready, and the output register loads only when rsp_ready_i is high
module bank_router (
  input  logic clk,
  input  logic reset,
  input  logic req_v_i,
  input  logic req_we_i,
  input  cache_geom_pkg::word_addr_t req_addr_i,
  input  cache_geom_pkg::data_t req_data_i,
  input  cache_geom_pkg::req_tag_t req_tag_i,
  output logic req_ready_o,
  output logic rsp_v_o,
  output logic rsp_we_o,
  output cache_geom_pkg::data_t rsp_data_o,
  output cache_geom_pkg::req_tag_t rsp_tag_o,
  input  logic rsp_ready_i,
  output logic [cache_geom_pkg::num_banks-1:0] bank_req_v_o,
  output logic bank_req_we_o,
  output cache_geom_pkg::word_addr_t bank_req_addr_o,
  output cache_geom_pkg::data_t bank_req_data_o,
  output cache_geom_pkg::req_tag_t bank_req_tag_o,
  input  logic [cache_geom_pkg::num_banks-1:0] bank_req_ready_i,
  input  logic [cache_geom_pkg::num_banks-1:0] bank_rsp_v_i,
  input  logic [cache_geom_pkg::num_banks-1:0] bank_rsp_we_i,
  input  cache_geom_pkg::data_t [cache_geom_pkg::num_banks-1:0] bank_rsp_data_i,
  input  cache_geom_pkg::req_tag_t [cache_geom_pkg::num_banks-1:0] bank_rsp_tag_i,
  output logic [cache_geom_pkg::num_banks-1:0] bank_rsp_yumi_o
);
  import cache_geom_pkg::*;

  bank_id_t req_bank;
  bank_id_t last_r;
  bank_id_t pick_id;
  logic     pick_v;
  logic     rsp_v_r;
  logic     rsp_we_r;
  data_t    rsp_data_r;
  req_tag_t rsp_tag_r;

  // interleave on the low word address bits
  assign req_bank    = req_addr_i[bank_id_w-1:0];
  assign req_ready_o = bank_req_ready_i[req_bank];

  always_comb begin
    bank_req_v_o = '0;
    bank_req_v_o[req_bank] = req_v_i;
  end

  assign bank_req_we_o   = req_we_i;
  assign bank_req_addr_o = req_addr_i;
  assign bank_req_data_o = req_data_i;
  assign bank_req_tag_o  = req_tag_i;

  // round robin, the bank after last_r wins first
  always_comb begin
    bank_id_t idx;
    pick_v  = 1'b0;
    pick_id = '0;
    for (int k = num_banks; k >= 1; k--) begin
      idx = bank_id_t'(last_r + k);
      if (bank_rsp_v_i[idx]) begin
        pick_v  = 1'b1;
        pick_id = idx;
      end
    end
  end

  always_comb begin
    bank_rsp_yumi_o = '0;
    bank_rsp_yumi_o[pick_id] = pick_v & rsp_ready_i;
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      rsp_v_r <= 1'b0;
      last_r  <= '0;
    end else if (rsp_ready_i) begin
      rsp_v_r <= pick_v;
      if (pick_v) begin
        last_r <= pick_id;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_ready_i && pick_v) begin
      rsp_we_r   <= bank_rsp_we_i[pick_id];
      rsp_data_r <= bank_rsp_data_i[pick_id];
      rsp_tag_r  <= bank_rsp_tag_i[pick_id];
    end
  end

  assign rsp_v_o    = rsp_v_r;
  assign rsp_we_o   = rsp_we_r;
  assign rsp_data_o = rsp_data_r;
  assign rsp_tag_o  = rsp_tag_r;

endmodule

/* logic/dram_pkg.sv */
// memory model of 4096 words with a fixed read latency and no stalls, counters wrap at 16 bits
package dram_pkg;

  localparam int dram_addr_w = 12;
  localparam int dram_words  = 1 << dram_addr_w;

  // cycles from accepting edge to read data
  localparam int dram_read_latency = 2;

  localparam int miss_count_w = 16;

  typedef logic [dram_addr_w-1:0]  dram_addr_t;
  typedef logic [miss_count_w-1:0] miss_count_t;

endpackage

/* logic/cache_geom_pkg.sv */
// fixed geometry of 4 banks interleaved on word address bits 1..0, 16 sets and one word per line
package cache_geom_pkg;

  localparam int word_addr_w = 12;
  localparam int data_w      = 32;
  localparam int req_tag_w   = 6;
  localparam int bank_id_w   = 2;
  localparam int set_idx_w   = 4;
  localparam int line_tag_w  = 6;

  localparam int num_banks = 1 << bank_id_w;
  localparam int num_sets  = 1 << set_idx_w;

  // field positions inside a word address
  localparam int set_lsb = bank_id_w;
  localparam int tag_lsb = bank_id_w + set_idx_w;

  typedef logic [word_addr_w-1:0] word_addr_t;
  typedef logic [data_w-1:0]      data_t;
  typedef logic [req_tag_w-1:0]   req_tag_t;
  typedef logic [bank_id_w-1:0]   bank_id_t;
  typedef logic [set_idx_w-1:0]   set_idx_t;
  typedef logic [line_tag_w-1:0]  line_tag_t;

endpackage
